/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary -Wall -Wno-fatal
TOP       ?= tb_ps2_keymap
FILELIST  ?= src.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

/* common/keymap_pkg.sv */
// keymap package
// shared types, ROM entry layout and key code constants for the PS/2 to Amiga mapper

package keymap_pkg;

  // widths
  localparam int CODE_W = 7;                  // amiga key code without release bit
  localparam int PS2_W  = 8;                  // one scan code set 2 byte

  // special flags, found in the code field when special is set
  localparam int SPECIAL_EXT_BIT = 0;         // E0 extended prefix
  localparam int SPECIAL_REL_BIT = 1;         // F0 release prefix
  localparam int SPECIAL_ACK_BIT = 2;         // FA acknowledge

  // amiga codes of the arrow keys, reused as joystick directions
  localparam logic [CODE_W-1:0] KEY_UP    = 7'h4c;
  localparam logic [CODE_W-1:0] KEY_DOWN  = 7'h4d;
  localparam logic [CODE_W-1:0] KEY_LEFT  = 7'h4f;
  localparam logic [CODE_W-1:0] KEY_RIGHT = 7'h4e;

  // keypad / and keypad * become mouse buttons
  localparam logic [CODE_W-1:0] KEY_LMB = 7'h5c;
  localparam logic [CODE_W-1:0] KEY_RMB = 7'h5d;

  typedef logic [PS2_W-1:0] ps2_byte_t;

  // release bit on top of the 7 bit code
  typedef logic [CODE_W:0] amiga_key_t;

  // one ROM word, 16 bits
  typedef struct packed {
    logic              amiga;                 // real amiga key
    logic              ctrl;                  // control
    logic              lalt;                  // left alt
    logic              ralt;                  // right alt
    logic              caps;                  // caps lock
    logic              numlock_key;           // the numlock key itself
    logic              keypad;                // held back while numlock is on
    logic              osd;                   // extra key for the OSD menu
    logic              special;               // prefix or ack byte
    logic [CODE_W-1:0] code;
  } keymap_entry_t;

  // active low joystick lines
  typedef struct packed {
    logic fire2;
    logic fire;
    logic up;
    logic down;
    logic left;
    logic right;
  } joy_t;

  localparam joy_t JOY_IDLE = '1;             // nothing pressed

endpackage

/* design/pad_emu.sv */
// pad emulation
// in numlock mode arrows, ctrl and left alt drive a joystick,
// keypad / and keypad * drive the mouse buttons

`timescale 1ns/1ps

module pad_emu (
  input  logic                      clk,
  input  logic                      reset,
  input  keymap_pkg::keymap_entry_t entry,
  input  logic                      entry_strobe,
  input  logic                      released,
  input  logic                      numlock,
  output keymap_pkg::joy_t          joy_n,
  output logic                      lmb_n,
  output logic                      rmb_n
);

  logic key_event;
  logic numlock_off;

  assign key_event = entry_strobe && entry.amiga;

  // numlock make while on, lines go idle on the same edge numlock drops
  assign numlock_off = !numlock ||
                       (entry_strobe && entry.numlock_key && !released);

  always_ff @(posedge clk) begin
    if (reset || numlock_off) begin
      joy_n <= keymap_pkg::JOY_IDLE;
      lmb_n <= 1'b1;
      rmb_n <= 1'b1;
    end else if (key_event) begin
      case (entry.code)
        keymap_pkg::KEY_RIGHT: begin
          joy_n.right <= released;
          if (!released) begin
            joy_n.left <= 1'b1;               // press cancels opposite
          end
        end
        keymap_pkg::KEY_LEFT: begin
          joy_n.left <= released;
          if (!released) begin
            joy_n.right <= 1'b1;
          end
        end
        keymap_pkg::KEY_DOWN: begin
          joy_n.down <= released;
          if (!released) begin
            joy_n.up <= 1'b1;
          end
        end
        keymap_pkg::KEY_UP: begin
          joy_n.up <= released;
          if (!released) begin
            joy_n.down <= 1'b1;
          end
        end
        keymap_pkg::KEY_LMB: lmb_n <= released;
        keymap_pkg::KEY_RMB: rmb_n <= released;
        default: ;
      endcase
      if (entry.ctrl) begin
        joy_n.fire <= released;
      end
      if (entry.lalt) begin
        joy_n.fire2 <= released;
      end
    end
  end

endmodule

/* design/ps2_keymap.sv */
// ps2 keymap top
// PS/2 set 2 bytes to amiga key codes, with OSD byte and numlock pad emulation

`timescale 1ns/1ps

module ps2_keymap (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   enable,
  input  keymap_pkg::ps2_byte_t  ps2_byte,
  output logic                   valid,
  output keymap_pkg::amiga_key_t akey,
  output logic                   ctrl,
  output logic                   aleft,
  output logic                   aright,
  output logic                   caps,
  output logic                   numlock,
  output keymap_pkg::amiga_key_t osd_ctrl,
  output keymap_pkg::joy_t       joy_n,
  output logic                   lmb_n,
  output logic                   rmb_n
);

  keymap_pkg::keymap_entry_t entry;
  logic                      entry_strobe;
  logic                      extended;        // selects the ROM page
  logic                      released;        // F0 seen before this key

  keymap_rom keymap_rom_inst (
    .clk          (clk),
    .reset        (reset),
    .enable       (enable),
    .ps2_byte     (ps2_byte),
    .extended     (extended),
    .entry        (entry),
    .entry_strobe (entry_strobe)
  );

  key_control key_control_inst (
    .clk          (clk),
    .reset        (reset),
    .entry        (entry),
    .entry_strobe (entry_strobe),
    .extended     (extended),
    .released     (released),
    .numlock      (numlock),
    .valid        (valid),
    .akey         (akey),
    .ctrl         (ctrl),
    .aleft        (aleft),
    .aright       (aright),
    .caps         (caps),
    .osd_ctrl     (osd_ctrl)
  );

  pad_emu pad_emu_inst (
    .clk          (clk),
    .reset        (reset),
    .entry        (entry),
    .entry_strobe (entry_strobe),
    .released     (released),
    .numlock      (numlock),
    .joy_n        (joy_n),
    .lmb_n        (lmb_n),
    .rmb_n        (rmb_n)
  );

endmodule

/* keymap/key_control.sv */
// key control
// follows the E0/F0/FA prefixes, keeps numlock, and builds the amiga key stream,
// modifier flags and OSD control byte from each ROM entry

`timescale 1ns/1ps

module key_control (
  input  logic                      clk,
  input  logic                      reset,
  input  keymap_pkg::keymap_entry_t entry,
  input  logic                      entry_strobe,
  output logic                      extended,
  output logic                      released,
  output logic                      numlock,
  output logic                      valid,
  output keymap_pkg::amiga_key_t    akey,
  output logic                      ctrl,
  output logic                      aleft,
  output logic                      aright,
  output logic                      caps,
  output keymap_pkg::amiga_key_t    osd_ctrl
);

  logic ext_code;
  logic rel_code;
  logic ack_code;
  logic arrow_code;
  logic held_back;

  // prefix decode, only meaningful on special entries
  assign ext_code = entry.special && entry.code[keymap_pkg::SPECIAL_EXT_BIT];
  assign rel_code = entry.special && entry.code[keymap_pkg::SPECIAL_REL_BIT];
  assign ack_code = entry.special && entry.code[keymap_pkg::SPECIAL_ACK_BIT];

  assign arrow_code = (entry.code == keymap_pkg::KEY_UP)   ||
                      (entry.code == keymap_pkg::KEY_DOWN) ||
                      (entry.code == keymap_pkg::KEY_LEFT) ||
                      (entry.code == keymap_pkg::KEY_RIGHT);

  // keys that go to the pad emulation instead of the amiga
  assign held_back = numlock &&
                     (entry.keypad || arrow_code || entry.ctrl || entry.lalt);

  always_ff @(posedge clk) begin
    if (reset) begin
      extended <= 1'b0;
      released <= 1'b0;
    end else if (entry_strobe) begin
      if (ext_code) begin
        extended <= 1'b1;
      end else if (rel_code) begin
        released <= 1'b1;
      end else if (!ack_code) begin
        extended <= 1'b0;                     // key consumed the prefixes
        released <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      numlock <= 1'b0;
    end else if (entry_strobe && entry.numlock_key && !released) begin
      numlock <= !numlock;                    // make only
    end
  end

  assign valid  = entry_strobe && entry.amiga && !held_back;
  assign akey   = {released, entry.code};
  assign ctrl   = entry.ctrl && !numlock;     // ctrl is joystick fire in numlock mode
  assign aleft  = entry.lalt && !numlock;
  assign aright = entry.ralt;
  assign caps   = entry.caps;

  // last osd or amiga key event, numlock mode does not filter it
  always_ff @(posedge clk) begin
    if (reset) begin
      osd_ctrl <= '0;
    end else if (entry_strobe && (entry.osd || entry.amiga)) begin
      osd_ctrl <= {released, entry.code};
    end
  end

endmodule

/* keymap/keymap_rom.sv */
// keymap ROM
// scan code set 2 lookup, two pages selected by the extended prefix state
// registered on enable, entry_strobe marks the new word for one cycle

`timescale 1ns/1ps

module keymap_rom (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     enable,
  input  keymap_pkg::ps2_byte_t    ps2_byte,
  input  logic                     extended,
  output keymap_pkg::keymap_entry_t entry,
  output logic                     entry_strobe
);

  function automatic keymap_pkg::keymap_entry_t lookup(input logic [8:0] addr);
    case (addr)
      // standard page
      9'h005: lookup = 16'h8050;              // f1
      9'h006: lookup = 16'h8051;              // f2
      9'h004: lookup = 16'h8052;              // f3
      9'h00c: lookup = 16'h8053;              // f4
      9'h003: lookup = 16'h8054;              // f5
      9'h00b: lookup = 16'h8055;              // f6
      9'h083: lookup = 16'h8056;              // f7
      9'h00a: lookup = 16'h8057;              // f8
      9'h001: lookup = 16'h8058;              // f9
      9'h009: lookup = 16'h8059;              // f10
      9'h007: lookup = 16'h0169;              // f12, osd
      9'h016: lookup = 16'h8001;              // 1
      9'h01e: lookup = 16'h8002;              // 2
      9'h026: lookup = 16'h8003;              // 3
      9'h025: lookup = 16'h8004;              // 4
      9'h02e: lookup = 16'h8005;              // 5
      9'h036: lookup = 16'h8006;              // 6
      9'h03d: lookup = 16'h8007;              // 7
      9'h03e: lookup = 16'h8008;              // 8
      9'h046: lookup = 16'h8009;              // 9
      9'h045: lookup = 16'h800a;              // 0
      9'h015: lookup = 16'h8010;              // q
      9'h01d: lookup = 16'h8011;              // w
      9'h024: lookup = 16'h8012;              // e
      9'h02d: lookup = 16'h8013;              // r
      9'h02c: lookup = 16'h8014;              // t
      9'h035: lookup = 16'h8015;              // y
      9'h03c: lookup = 16'h8016;              // u
      9'h043: lookup = 16'h8017;              // i
      9'h044: lookup = 16'h8018;              // o
      9'h04d: lookup = 16'h8019;              // p
      9'h01c: lookup = 16'h8020;              // a
      9'h01b: lookup = 16'h8021;              // s
      9'h023: lookup = 16'h8022;              // d
      9'h02b: lookup = 16'h8023;              // f
      9'h034: lookup = 16'h8024;              // g
      9'h033: lookup = 16'h8025;              // h
      9'h03b: lookup = 16'h8026;              // j
      9'h042: lookup = 16'h8027;              // k
      9'h04b: lookup = 16'h8028;              // l
      9'h01a: lookup = 16'h8031;              // z
      9'h022: lookup = 16'h8032;              // x
      9'h021: lookup = 16'h8033;              // c
      9'h02a: lookup = 16'h8034;              // v
      9'h032: lookup = 16'h8035;              // b
      9'h031: lookup = 16'h8036;              // n
      9'h03a: lookup = 16'h8037;              // m
      9'h029: lookup = 16'h8040;              // space
      9'h066: lookup = 16'h8041;              // backspace
      9'h00d: lookup = 16'h8042;              // tab
      9'h05a: lookup = 16'h8044;              // enter
      9'h076: lookup = 16'h8045;              // escape
      9'h012: lookup = 16'h8060;              // left shift
      9'h059: lookup = 16'h8061;              // right shift
      9'h058: lookup = 16'h8862;              // caps lock
      9'h014: lookup = 16'hc063;              // ctrl
      9'h011: lookup = 16'ha064;              // left alt
      9'h077: lookup = 16'h0400;              // numlock
      9'h070: lookup = 16'h820f;              // kp 0
      9'h069: lookup = 16'h821d;              // kp 1
      9'h072: lookup = 16'h821e;              // kp 2
      9'h07a: lookup = 16'h821f;              // kp 3
      9'h06b: lookup = 16'h822d;              // kp 4
      9'h073: lookup = 16'h822e;              // kp 5
      9'h074: lookup = 16'h822f;              // kp 6
      9'h06c: lookup = 16'h823d;              // kp 7
      9'h075: lookup = 16'h823e;              // kp 8
      9'h07d: lookup = 16'h823f;              // kp 9
      9'h071: lookup = 16'h823c;              // kp .
      9'h07b: lookup = 16'h824a;              // kp -
      9'h079: lookup = 16'h825e;              // kp +
      9'h07c: lookup = 16'h825d;              // kp *
      9'h0e0: lookup = 16'h0081;              // extended prefix
      9'h0f0: lookup = 16'h0082;              // release prefix
      9'h0fa: lookup = 16'h0084;              // ack
      // extended page
      9'h111: lookup = 16'h9065;              // right alt
      9'h11f: lookup = 16'h8066;              // left gui, left amiga
      9'h127: lookup = 16'h8067;              // right gui, right amiga
      9'h14a: lookup = 16'h825c;              // kp /
      9'h15a: lookup = 16'h8243;              // kp enter
      9'h175: lookup = 16'h804c;              // arrow up
      9'h172: lookup = 16'h804d;              // arrow down
      9'h174: lookup = 16'h804e;              // arrow right
      9'h16b: lookup = 16'h804f;              // arrow left
      9'h16c: lookup = 16'h016a;              // home, osd
      9'h169: lookup = 16'h016b;              // end, osd
      9'h17d: lookup = 16'h016c;              // page up, osd
      9'h17a: lookup = 16'h016d;              // page down, osd
      9'h17c: lookup = 16'h016e;              // print screen, osd
      9'h1e0: lookup = 16'h0081;              // prefixes repeat on this page
      9'h1f0: lookup = 16'h0082;
      9'h1fa: lookup = 16'h0084;
      default: lookup = '0;                   // unmapped byte
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (enable) begin
      entry <= lookup({extended, ps2_byte});
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      entry_strobe <= 1'b0;
    end else begin
      entry_strobe <= enable;                 // entry is fresh for one cycle
    end
  end

endmodule

/* src.f */
+incdir+tests
common/keymap_pkg.sv
keymap/keymap_rom.sv
keymap/key_control.sv
design/pad_emu.sv
design/ps2_keymap.sv
tests/tb_ps2_keymap.sv

/* tests/keymap_model.svh */
// keymap reference model
// own copy of the kept scan code table and the prefix, numlock and pad rules
`ifndef KEYMAP_MODEL_SVH
`define KEYMAP_MODEL_SVH

// key word: kind, page, ps2 byte, amiga code (24'hKEBBCC)
// kinds: 0 plain, 1 keypad, 2 osd, 3 caps, 4 ctrl, 5 lalt, 6 ralt, 7 numlock
localparam int KEY_COUNT = 86;
localparam logic [23:0] KEY_LIST [KEY_COUNT] = '{
  24'h000550, 24'h000651, 24'h000452, 24'h000c53, 24'h000354, 24'h000b55,
  24'h008356, 24'h000a57, 24'h000158, 24'h000959, 24'h001601, 24'h001e02,
  24'h002603, 24'h002504, 24'h002e05, 24'h003606, 24'h003d07, 24'h003e08,
  24'h004609, 24'h00450a, 24'h001510, 24'h001d11, 24'h002412, 24'h002d13,
  24'h002c14, 24'h003515, 24'h003c16, 24'h004317, 24'h004418, 24'h004d19,
  24'h001c20, 24'h001b21, 24'h002322, 24'h002b23, 24'h003424, 24'h003325,
  24'h003b26, 24'h004227, 24'h004b28, 24'h001a31, 24'h002232, 24'h002133,
  24'h002a34, 24'h003235, 24'h003136, 24'h003a37, 24'h002940, 24'h006641,
  24'h000d42, 24'h005a44, 24'h007645, 24'h001260, 24'h005961,
  24'h10700f, 24'h10691d, 24'h10721e, 24'h107a1f, 24'h106b2d, 24'h10732e,
  24'h10742f, 24'h106c3d, 24'h10753e, 24'h107d3f, 24'h10713c, 24'h107b4a,
  24'h10795e, 24'h107c5d, 24'h114a5c, 24'h115a43,
  24'h011f66, 24'h012767, 24'h01754c, 24'h01724d, 24'h01744e, 24'h016b4f,
  24'h200769, 24'h216c6a, 24'h21696b, 24'h217d6c, 24'h217a6d, 24'h217c6e,
  24'h305862, 24'h401463, 24'h501164, 24'h611165, 24'h707700
};

logic                   m_ext;
logic                   m_rel;
logic                   m_numlock;
keymap_pkg::amiga_key_t m_osd;
logic [5:0]             m_joy;                // right, left, down, up, fire, fire2
logic                   m_lmb;
logic                   m_rmb;

task automatic model_reset();
  m_ext = 1'b0;
  m_rel = 1'b0;
  m_numlock = 1'b0;
  m_osd = '0;
  m_joy = 6'h3f;
  m_lmb = 1'b1;
  m_rmb = 1'b1;
endtask

function automatic keymap_pkg::keymap_entry_t expected_entry(input logic ext,
                                                             input logic [7:0] b);
  keymap_pkg::keymap_entry_t e;
  logic [3:0]                kind;
  e = '0;
  if (b == 8'he0 || b == 8'hf0 || b == 8'hfa) begin
    e.special = 1'b1;                         // prefixes on both pages
    e.code = (b == 8'he0) ? 7'd1 : (b == 8'hf0) ? 7'd2 : 7'd4;
  end else begin
    for (int i = 0; i < KEY_COUNT; i++) begin
      if (KEY_LIST[i][16] == ext && KEY_LIST[i][15:8] == b) begin
        kind = KEY_LIST[i][23:20];
        e.code = KEY_LIST[i][6:0];
        e.amiga = (kind != 4'd2) && (kind != 4'd7);   // osd and numlock keys stay local
        case (kind)
          4'd1: e.keypad = 1'b1;
          4'd2: e.osd = 1'b1;
          4'd3: e.caps = 1'b1;
          4'd4: e.ctrl = 1'b1;
          4'd5: e.lalt = 1'b1;
          4'd6: e.ralt = 1'b1;
          4'd7: e.numlock_key = 1'b1;
          default: ;
        endcase
      end
    end
  end
  return e;
endfunction

// state change on the edge that ends the strobe cycle
task automatic model_apply(input keymap_pkg::keymap_entry_t e);
  logic nl_make;
  int   dir;
  nl_make = e.numlock_key && !m_rel;
  dir = -1;
  if (!m_numlock || nl_make) begin
    m_joy = 6'h3f;
    m_lmb = 1'b1;
    m_rmb = 1'b1;
  end else if (e.amiga) begin
    case (e.code)
      7'h4e: dir = 0;                         // right
      7'h4f: dir = 1;                         // left
      7'h4d: dir = 2;                         // down
      7'h4c: dir = 3;                         // up
      7'h5c: m_lmb = m_rel;
      7'h5d: m_rmb = m_rel;
      default: ;
    endcase
    if (dir >= 0) begin
      m_joy[dir] = m_rel;
      if (!m_rel) begin
        m_joy[dir ^ 1] = 1'b1;                // press lets go of the opposite line
      end
    end
    if (e.ctrl) m_joy[4] = m_rel;
    if (e.lalt) m_joy[5] = m_rel;
  end
  if (nl_make) m_numlock = !m_numlock;
  if (e.osd || e.amiga) m_osd = {m_rel, e.code};
  if (e.special && e.code[0]) m_ext = 1'b1;
  else if (e.special && e.code[1]) m_rel = 1'b1;
  else if (!(e.special && e.code[2])) begin
    m_ext = 1'b0;
    m_rel = 1'b0;
  end
endtask

`endif

/* tests/tb_ps2_keymap.sv */
// testbench for the PS/2 to amiga keymap
// random key events against the reference model in keymap_model.svh

`timescale 1ns/1ps

module tb_ps2_keymap;

  logic                   clk;
  logic                   reset;
  logic                   enable;
  keymap_pkg::ps2_byte_t  ps2_byte;
  logic                   valid;
  keymap_pkg::amiga_key_t akey;
  logic                   ctrl;
  logic                   aleft;
  logic                   aright;
  logic                   caps;
  logic                   numlock;
  keymap_pkg::amiga_key_t osd_ctrl;
  keymap_pkg::joy_t       joy_n;
  logic                   lmb_n;
  logic                   rmb_n;

  logic                   strobe_q;           // DUT saw enable last edge
  logic                   state_q;            // state outputs settle now
  keymap_pkg::ps2_byte_t  byte_q;
  logic                   checking;

  `include "keymap_model.svh"

  ps2_keymap ps2_keymap_inst (
    .clk      (clk),
    .reset    (reset),
    .enable   (enable),
    .ps2_byte (ps2_byte),
    .valid    (valid),
    .akey     (akey),
    .ctrl     (ctrl),
    .aleft    (aleft),
    .aright   (aright),
    .caps     (caps),
    .numlock  (numlock),
    .osd_ctrl (osd_ctrl),
    .joy_n    (joy_n),
    .lmb_n    (lmb_n),
    .rmb_n    (rmb_n)
  );

  always #20 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_key(input logic exp_valid, input logic got_valid,
                           input keymap_pkg::amiga_key_t exp_key,
                           input keymap_pkg::amiga_key_t got_key);
    if (got_valid !== exp_valid) begin
      fail_run($sformatf("** Error at %0t: valid %b, expected %b", $time, got_valid, exp_valid));
    end else if (exp_valid && got_key !== exp_key) begin
      fail_run($sformatf("** Error at %0t: akey %h, expected %h", $time, got_key, exp_key));
    end
  endtask

  task automatic check_flags(input logic [3:0] exp_flags, input logic [3:0] got_flags);
    if (got_flags !== exp_flags) begin
      fail_run($sformatf("** Error at %0t: ctrl/aleft/aright/caps %b, expected %b",
                         $time, got_flags, exp_flags));
    end
  endtask

  task automatic check_osd(input keymap_pkg::amiga_key_t exp_osd,
                           input keymap_pkg::amiga_key_t got_osd);
    if (got_osd !== exp_osd) begin
      fail_run($sformatf("** Error at %0t: osd_ctrl %h, expected %h", $time, got_osd, exp_osd));
    end
  endtask

  task automatic check_pad(input keymap_pkg::joy_t exp_joy, input logic [1:0] exp_btn,
                           input keymap_pkg::joy_t got_joy, input logic [1:0] got_btn);
    if (got_joy !== exp_joy || got_btn !== exp_btn) begin
      fail_run($sformatf("** Error at %0t: joy_n %b lmb/rmb %b, expected %b %b",
                         $time, got_joy, got_btn, exp_joy, exp_btn));
    end
  endtask

  task automatic check_numlock(input logic exp_nl, input logic got_nl);
    if (got_nl !== exp_nl) begin
      fail_run($sformatf("** Error at %0t: numlock %b, expected %b", $time, got_nl, exp_nl));
    end
  endtask

  task automatic key_cycle(input keymap_pkg::ps2_byte_t b);
    keymap_pkg::keymap_entry_t e;
    logic                      held;
    e = expected_entry(m_ext, b);
    held = m_numlock && (e.keypad || e.ctrl || e.lalt || (e.code >= 7'h4c && e.code <= 7'h4f));
    check_key(e.amiga && !held, valid, {m_rel, e.code}, akey);
    check_flags({e.ctrl && !m_numlock, e.lalt && !m_numlock, e.ralt, e.caps},
                {ctrl, aleft, aright, caps});
    model_apply(e);
  endtask

  task automatic state_cycle();
    check_numlock(m_numlock, numlock);
    check_osd(m_osd, osd_ctrl);
    check_pad(m_joy, {m_lmb, m_rmb}, joy_n, {lmb_n, rmb_n});
  endtask

  always @(posedge clk) begin
    strobe_q <= reset ? 1'b0 : enable;
    state_q <= strobe_q;
    byte_q <= ps2_byte;
  end

  always @(negedge clk) begin
    if (checking) begin
      if (state_q) state_cycle();             // before the next key, same edge
      if (strobe_q) key_cycle(byte_q);
      else check_key(1'b0, valid, '0, akey);
    end
  end

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
    end
  endtask

  task automatic send_byte(input keymap_pkg::ps2_byte_t b);
    int gap;
    gap = 2 + ($urandom % 4);                 // 2 to 5 cycles between enables
    @(posedge clk);
    enable <= 1'b1;
    ps2_byte <= b;
    @(posedge clk);
    enable <= 1'b0;
    wait_cycles(gap - 2);
  endtask

  task automatic send_event();
    int                    r;
    int                    idx;
    logic [23:0]           w;
    keymap_pkg::ps2_byte_t b;
    r = $urandom % 100;
    if (r < 4) begin
      send_byte(8'hfa);                       // stray ack
    end else if (r < 8) begin
      b = $urandom % 256;
      if (b == 8'he0 || b == 8'hf0 || b == 8'hfa) b = 8'h00;
      send_byte(b);
    end else begin
      idx = (r < 14) ? KEY_COUNT - 1 : ($urandom % KEY_COUNT);
      w = KEY_LIST[idx];
      if (w[16]) send_byte(8'he0);
      if ($urandom % 2) send_byte(8'hf0);
      if (($urandom % 8) == 0) send_byte(8'hfa);   // ack between prefix and key
      send_byte(w[15:8]);
    end
  endtask

  initial begin
    int timeout;
    clk = 1'b0;
    reset = 1'b1;
    enable = 1'b0;
    ps2_byte = '0;
    checking = 1'b0;
    void'($urandom(41));
    model_reset();
    wait_cycles(16);
    reset <= 1'b0;
    @(negedge clk);
    check_key(1'b0, valid, '0, akey);
    state_cycle();
    checking = 1'b1;
    for (int i = 0; i < 800; i++) begin
      send_event();
    end
    timeout = 0;
    @(negedge clk);
    while ((strobe_q || state_q) && timeout < 10) begin
      @(negedge clk);
      timeout++;
    end
    if (strobe_q || state_q) begin
      fail_run("the last key event never finished");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

  initial begin
    #2ms;
    fail_run("simulation ran too long, stimulus hung");
  end

endmodule
